// File: source/sv39_pkg.sv
package sv39_pkg;

    // --------------------------------------------------
    // architectural widths
    // --------------------------------------------------
    // sv39 virtual address, upper bits sign-extend bit 38
    localparam int unsigned VLEN = 39;
    // physical address as driven towards memory
    localparam int unsigned PLEN = 56;
    // register width, used for tval
    localparam int unsigned XLEN = 64;
    // ppn[2:0] concatenated, 26 + 9 + 9 bits
    localparam int unsigned PPNW = 44;
    // 4 KiB page offset
    localparam int unsigned PG_OFFSET_W = 12;
    // vpn[2:0], three levels of 9 bits
    localparam int unsigned VPNW = VLEN - PG_OFFSET_W;

    typedef logic [VLEN-1:0] vaddr_t;
    typedef logic [PLEN-1:0] paddr_t;
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [PPNW-1:0] ppn_t;
    typedef logic [VPNW-1:0] vpn_t;

    // --------------------------------------------------
    // page table entry
    // --------------------------------------------------
    // layout as in memory, msb first
    typedef struct packed {
        // must be zero for sv39
        logic [9:0] reserved;
        ppn_t       ppn;
        // reserved for software
        logic [1:0] rsw;
        // dirty, page has been written
        logic       d;
        // accessed
        logic       a;
        // global mapping
        logic       g;
        // user accessible
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // --------------------------------------------------
    // privilege and exceptions
    // --------------------------------------------------
    // encoding 2 is reserved (hypervisor)
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_t;

    // mcause exception code field
    typedef logic [5:0] cause_t;

    localparam cause_t LOAD_PAGE_FAULT  = 6'd13;
    localparam cause_t STORE_PAGE_FAULT = 6'd15;

endpackage

// File: source/mmu_pkg.sv
package mmu_pkg;

    // --------------------------------------------------
    // implementation sizes
    // --------------------------------------------------
    // fully associative, one entry per way
    localparam int unsigned DTLB_ENTRIES = 4;

    // round-robin fill pointer
    typedef logic [$clog2(DTLB_ENTRIES)-1:0] tlb_idx_t;

    // --------------------------------------------------
    // structs between the blocks
    // --------------------------------------------------
    // fill strobe, valid for one cycle only
    typedef struct packed {
        logic              valid;
        logic              is_2m;
        logic              is_1g;
        sv39_pkg::vpn_t    vpn;
        sv39_pkg::pte_t    content;
    } tlb_update_t;

    // combinational lookup result from the tlb
    typedef struct packed {
        logic              hit;
        logic              is_2m;
        logic              is_1g;
        sv39_pkg::pte_t    content;
    } tlb_lookup_t;

    // response exception record
    typedef struct packed {
        sv39_pkg::cause_t  cause;
        sv39_pkg::xlen_t   tval;
        logic              valid;
    } exception_t;

    // load/store request, valid is a strobe
    typedef struct packed {
        logic              valid;
        sv39_pkg::vaddr_t  vaddr;
        logic              is_store;
    } lsu_req_t;

endpackage

// File: source/dtlb.sv
`timescale 1ns/1ps

module dtlb (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  mmu_pkg::tlb_update_t update_i,
    input  logic                 lu_access_i,
    input  sv39_pkg::vaddr_t     lu_vaddr_i,
    output mmu_pkg::tlb_lookup_t lu_o
);

    import sv39_pkg::*;
    import mmu_pkg::*;

    // tag side of every entry
    vpn_t                    tag_vpn_q [DTLB_ENTRIES];
    logic [DTLB_ENTRIES-1:0] tag_2m_q;
    logic [DTLB_ENTRIES-1:0] tag_1g_q;
    // data side, the leaf pte
    pte_t                    content_q [DTLB_ENTRIES];
    logic [DTLB_ENTRIES-1:0] valid_q;
    // next entry to be replaced
    tlb_idx_t                rr_q;

    vpn_t                    lu_vpn;
    logic [DTLB_ENTRIES-1:0] hit_vec;
    logic                    fill;

    assign lu_vpn = lu_vaddr_i[VLEN-1:PG_OFFSET_W];
    // a flush in the same cycle drops the fill
    assign fill = update_i.valid & ~flush_i;

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------
    // all entries compared in parallel
    // vpn[2] always, vpn[1] unless giga, vpn[0] only for 4k
    always_comb begin : compare
        for (int i = 0; i < DTLB_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i]
                & (tag_vpn_q[i][26:18] == lu_vpn[26:18])
                & (tag_1g_q[i] | (tag_vpn_q[i][17:9] == lu_vpn[17:9]))
                & (tag_1g_q[i] | tag_2m_q[i] | (tag_vpn_q[i][8:0] == lu_vpn[8:0]));
        end
    end

    // select the hitting entry
    // at most one entry hits, so the loop order does not matter
    always_comb begin : out_mux
        lu_o = '0;
        for (int i = 0; i < DTLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                lu_o.is_2m   = tag_2m_q[i];
                lu_o.is_1g   = tag_1g_q[i];
                lu_o.content = content_q[i];
            end
        end
        // only report a hit for an actual access
        lu_o.hit = lu_access_i & (|hit_vec);
    end

    // --------------------------------------------------
    // fill and flush
    // --------------------------------------------------
    // valid bits and round-robin pointer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            // whole tlb invalidated, pointer keeps going
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[rr_q] <= 1'b1;
            // wrap at the last entry
            if (rr_q == tlb_idx_t'(DTLB_ENTRIES - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

    // tag and content written at the pointer
    // visible to lookups from the next cycle
    always_ff @(posedge clk_i) begin
        if (fill) begin
            tag_vpn_q[rr_q] <= update_i.vpn;
            tag_2m_q[rr_q]  <= update_i.is_2m;
            tag_1g_q[rr_q]  <= update_i.is_1g;
            content_q[rr_q] <= update_i.content;
        end
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------
    // whoever fills the tlb must keep the mapped pages disjoint
    a_hit_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_vec)
    ) else $error("dtlb: more than one entry hits");

    // a page is either mega or giga, never both
    a_update_size : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        update_i.valid |-> !(update_i.is_2m && update_i.is_1g)
    ) else $error("dtlb: update with both is_2m and is_1g");

endmodule

// File: source/ld_st_translate.sv
`timescale 1ns/1ps

module ld_st_translate (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mmu_pkg::lsu_req_t    req_i,
    input  mmu_pkg::tlb_lookup_t lu_i,
    input  logic                 en_translation_i,
    input  sv39_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                 sum_i,
    output logic                 dtlb_hit_o,
    output logic                 dtlb_miss_o,
    output logic                 valid_o,
    output sv39_pkg::ppn_t       dtlb_ppn_o,
    output sv39_pkg::paddr_t     paddr_o,
    output mmu_pkg::exception_t  exception_o
);

    import sv39_pkg::*;
    import mmu_pkg::*;

    // request register
    logic        req_valid_q;
    vaddr_t      vaddr_q;
    logic        is_store_q;
    // mode sampled together with the request
    logic        en_q;
    priv_lvl_t   priv_q;
    logic        sum_q;
    // registered tlb response
    tlb_lookup_t lu_q;

    logic        access_err;
    xlen_t       tval;

    // --------------------------------------------------
    // cycle 0
    // --------------------------------------------------
    // without translation every request counts as a hit
    assign dtlb_hit_o  = en_translation_i ? lu_i.hit : 1'b1;
    assign dtlb_miss_o = req_i.valid & en_translation_i & ~lu_i.hit;

    // early ppn, same superpage substitution as the paddr
    always_comb begin : ppn_early
        dtlb_ppn_o = ppn_t'(req_i.vaddr[VLEN-1:PG_OFFSET_W]);
        if (en_translation_i) begin
            dtlb_ppn_o = lu_i.content.ppn;
            // ppn[0] from the vaddr
            if (lu_i.is_2m) begin
                dtlb_ppn_o[8:0] = req_i.vaddr[20:12];
            end
            // ppn[1:0] from the vaddr
            if (lu_i.is_1g) begin
                dtlb_ppn_o[17:0] = req_i.vaddr[29:12];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= req_i.vaddr;
        is_store_q <= req_i.is_store;
        en_q       <= en_translation_i;
        priv_q     <= priv_lvl_i;
        sum_q      <= sum_i;
        lu_q       <= lu_i;
    end

    // --------------------------------------------------
    // cycle 1
    // --------------------------------------------------
    // a miss is never answered, the requester retries after the fill
    assign valid_o = req_valid_q & (~en_q | lu_q.hit);

    // 4k page first, then the superpage bits from the vaddr
    always_comb begin : paddr_build
        paddr_o = paddr_t'(vaddr_q);
        if (en_q) begin
            paddr_o = {lu_q.content.ppn, vaddr_q[PG_OFFSET_W-1:0]};
            if (lu_q.is_2m) begin
                paddr_o[20:12] = vaddr_q[20:12];
            end
            if (lu_q.is_1g) begin
                paddr_o[29:12] = vaddr_q[29:12];
            end
        end
    end

    // user page from s-mode needs sum, u-mode needs a user page
    // m-mode is never denied
    assign access_err = ((priv_q == PRIV_S) & ~sum_q & lu_q.content.u)
                      | ((priv_q == PRIV_U) & ~lu_q.content.u);

    // bad address is the sign-extended vaddr
    assign tval = {{(XLEN - VLEN){vaddr_q[VLEN-1]}}, vaddr_q};

    always_comb begin : exc_select
        exception_o = '0;
        if (valid_o && en_q) begin
            if (is_store_q) begin
                // stores also need a writable and dirty page
                if (access_err || !lu_q.content.w || !lu_q.content.d) begin
                    exception_o.cause = STORE_PAGE_FAULT;
                    exception_o.tval  = tval;
                    exception_o.valid = 1'b1;
                end
            end else if (access_err) begin
                exception_o.cause = LOAD_PAGE_FAULT;
                exception_o.tval  = tval;
                exception_o.valid = 1'b1;
            end
        end
    end

endmodule

// File: source/mmu_data.sv
`timescale 1ns/1ps

module mmu_data (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // translation control
    input  logic                 en_ld_st_translation_i,
    input  sv39_pkg::priv_lvl_t  ld_st_priv_lvl_i,
    input  logic                 sum_i,
    // tlb maintenance
    input  logic                 flush_tlb_i,
    input  mmu_pkg::tlb_update_t tlb_update_i,
    // load/store request
    input  mmu_pkg::lsu_req_t    lsu_req_i,
    // cycle 0
    output logic                 dtlb_hit_o,
    output sv39_pkg::ppn_t       dtlb_ppn_o,
    output logic                 dtlb_miss_o,
    // cycle 1
    output logic                 lsu_valid_o,
    output sv39_pkg::paddr_t     lsu_paddr_o,
    output mmu_pkg::exception_t  lsu_exception_o
);

    import mmu_pkg::*;

    // tlb result towards the translation stage
    tlb_lookup_t dtlb_lu;

    // --------------------------------------------------
    // data tlb
    // --------------------------------------------------
    dtlb i_dtlb (
        .clk_i       ( clk_i           ),
        .rst_ni      ( rst_ni          ),
        .flush_i     ( flush_tlb_i     ),
        .update_i    ( tlb_update_i    ),
        .lu_access_i ( lsu_req_i.valid ),
        .lu_vaddr_i  ( lsu_req_i.vaddr ),
        .lu_o        ( dtlb_lu         )
    );

    // --------------------------------------------------
    // translation stage
    // --------------------------------------------------
    ld_st_translate i_ld_st_translate (
        .clk_i            ( clk_i                  ),
        .rst_ni           ( rst_ni                 ),
        .req_i            ( lsu_req_i              ),
        .lu_i             ( dtlb_lu                ),
        .en_translation_i ( en_ld_st_translation_i ),
        .priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .sum_i            ( sum_i                  ),
        .dtlb_hit_o       ( dtlb_hit_o             ),
        .dtlb_miss_o      ( dtlb_miss_o            ),
        .valid_o          ( lsu_valid_o            ),
        .dtlb_ppn_o       ( dtlb_ppn_o             ),
        .paddr_o          ( lsu_paddr_o            ),
        .exception_o      ( lsu_exception_o        )
    );

endmodule

// File: verif/mmu_ref_model.svh
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

// expected cycle-0 and cycle-1 results of one request
typedef struct packed {
    logic   hit0;
    logic   miss0;
    logic   ppn_chk;
    ppn_t   ppn0;
    logic   valid1;
    paddr_t paddr1;
    logic   exc_valid;
    cause_t cause;
    xlen_t  tval;
} expect_t;

// shadow tlb
// size code 0 is 4k, 1 is 2m, 2 is 1g
vpn_t       ref_vpn   [DTLB_ENTRIES];
logic [1:0] ref_size  [DTLB_ENTRIES];
pte_t       ref_pte   [DTLB_ENTRIES];
logic       ref_valid [DTLB_ENTRIES];
tlb_idx_t   ref_ptr;

function automatic void ref_flush();
    foreach (ref_valid[i]) begin
        ref_valid[i] = 1'b0;
    end
endfunction

// oldest entry replaced first
function automatic void ref_fill(tlb_update_t u);
    ref_vpn[ref_ptr]   = u.vpn;
    ref_size[ref_ptr]  = u.is_1g ? 2'd2 : (u.is_2m ? 2'd1 : 2'd0);
    ref_pte[ref_ptr]   = u.content;
    ref_valid[ref_ptr] = 1'b1;
    ref_ptr            = ref_ptr + 1'b1;
endfunction

function automatic expect_t ref_expect(lsu_req_t r, logic en, priv_lvl_t priv, logic sum);
    expect_t e;
    vpn_t    vpn;
    int      idx;
    int      low;
    ppn_t    keep;
    logic    deny;
    logic    fault;
    e   = '0;
    idx = -1;
    vpn = r.vaddr[VLEN-1:PG_OFFSET_W];
    if (!en) begin
        e.hit0   = 1'b1;
        e.valid1 = r.valid;
        e.paddr1 = paddr_t'(r.vaddr);
        return e;
    end
    // a superpage ignores 9 or 18 low vpn bits
    for (int i = 0; i < DTLB_ENTRIES; i++) begin
        low = 9 * int'(ref_size[i]);
        if (ref_valid[i] && ((ref_vpn[i] >> low) == (vpn >> low))) begin
            idx = i;
        end
    end
    e.hit0  = r.valid && idx >= 0;
    e.miss0 = r.valid && idx < 0;
    if (idx < 0) begin
        return e;
    end
    low       = 9 * int'(ref_size[idx]);
    keep      = ~(ppn_t'('1) << low);
    e.ppn_chk = r.valid;
    e.ppn0    = (ref_pte[idx].ppn & ~keep) | (ppn_t'(vpn) & keep);
    e.valid1  = r.valid;
    e.paddr1  = {e.ppn0, r.vaddr[PG_OFFSET_W-1:0]};
    deny  = (priv == PRIV_S && !sum && ref_pte[idx].u) || (priv == PRIV_U && !ref_pte[idx].u);
    fault = r.is_store ? (deny || !ref_pte[idx].w || !ref_pte[idx].d) : deny;
    if (r.valid && fault) begin
        e.exc_valid = 1'b1;
        e.cause     = r.is_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        e.tval      = xlen_t'($signed(r.vaddr));
    end
    return e;
endfunction

`endif

// File: verif/tb_mmu_data.sv
`timescale 1ns/1ps

module tb_mmu_data;

    import sv39_pkg::*;
    import mmu_pkg::*;

    `include "mmu_ref_model.svh"

    // cycles allowed for outstanding responses to drain
    localparam int unsigned DRAIN_LIMIT = 20;

    logic        clk;
    logic        rst_n;
    logic        en;
    priv_lvl_t   priv;
    logic        sum;
    logic        flush;
    tlb_update_t upd;
    lsu_req_t    req;
    logic        hit;
    logic        miss;
    logic        valid;
    ppn_t        ppn;
    paddr_t      paddr;
    exception_t  exc;

    // mode applied by the next step
    logic        cfg_en;
    priv_lvl_t   cfg_priv;
    logic        cfg_sum;
    // expected cycle-1 results, one per step
    expect_t     exp_q [$];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          test_err;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    mmu_data dut (
        .clk_i                  ( clk   ),
        .rst_ni                 ( rst_n ),
        .en_ld_st_translation_i ( en    ),
        .ld_st_priv_lvl_i       ( priv  ),
        .sum_i                  ( sum   ),
        .flush_tlb_i            ( flush ),
        .tlb_update_i           ( upd   ),
        .lsu_req_i              ( req   ),
        .dtlb_hit_o             ( hit   ),
        .dtlb_ppn_o             ( ppn   ),
        .dtlb_miss_o            ( miss  ),
        .lsu_valid_o            ( valid ),
        .lsu_paddr_o            ( paddr ),
        .lsu_exception_o        ( exc   )
    );

    initial begin : clock
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic pte_t make_pte(ppn_t p, logic u, logic w, logic d);
        pte_t t;
        t     = '0;
        t.ppn = p;
        t.u   = u;
        t.w   = w;
        t.d   = d;
        t.a   = 1'b1;
        t.r   = 1'b1;
        t.v   = 1'b1;
        return t;
    endfunction

    task automatic compare_value(string name, logic [63:0] exp_v, logic [63:0] got);
        checks++;
        if (exp_v !== got) begin
            errors++;
            $display("FAIL %0t ns %s expected %h got %h", $time, name, exp_v, got);
        end
    endtask

    // --------------------------------------------------
    // one cycle of stimulus
    // --------------------------------------------------
    // drive, check cycle 0, queue cycle 1, then update the shadow tlb
    task automatic step(lsu_req_t r, tlb_update_t u, logic fl);
        expect_t e;
        @(posedge clk);
        #1;
        req   = r;
        upd   = u;
        flush = fl;
        en    = cfg_en;
        priv  = cfg_priv;
        sum   = cfg_sum;
        #1;
        e = ref_expect(r, en, priv, sum);
        compare_value("dtlb_hit_o", 64'(e.hit0), 64'(hit));
        compare_value("dtlb_miss_o", 64'(e.miss0), 64'(miss));
        if (e.ppn_chk) begin
            compare_value("dtlb_ppn_o", 64'(e.ppn0), 64'(ppn));
        end
        exp_q.push_back(e);
        // flush wins over a fill in the same cycle
        if (fl) begin
            ref_flush();
        end else if (u.valid) begin
            ref_fill(u);
        end
    endtask

    task automatic access(vaddr_t va, logic st);
        lsu_req_t r;
        r.valid    = 1'b1;
        r.vaddr    = va;
        r.is_store = st;
        step(r, '0, 1'b0);
    endtask

    task automatic fill(vpn_t vpn, logic is_2m, logic is_1g, pte_t pte, logic fl);
        tlb_update_t u;
        u.valid   = 1'b1;
        u.is_2m   = is_2m;
        u.is_1g   = is_1g;
        u.vpn     = vpn;
        u.content = pte;
        step('0, u, fl);
    endtask

    // wait for the queue to empty, then report the test
    task automatic finish_test(string name);
        int n;
        n = 0;
        step('0, '0, 1'b0);
        while (exp_q.size() > 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            timed_out = 1'b1;
            $display("timeout in %s: expected responses never drained", name);
        end
        tests_run++;
        if (errors != test_err || timed_out) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // --------------------------------------------------
    // response compare, half a ns after the edge
    // --------------------------------------------------
    initial begin : compare
        expect_t e;
        forever begin
            @(posedge clk);
            #0.5;
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_value("lsu_valid_o", 64'(e.valid1), 64'(valid));
                if (e.valid1) begin
                    compare_value("lsu_paddr_o", 64'(e.paddr1), 64'(paddr));
                end
                compare_value("lsu_exception_o.valid", 64'(e.exc_valid), 64'(exc.valid));
                if (e.exc_valid) begin
                    compare_value("lsu_exception_o.cause", 64'(e.cause), 64'(exc.cause));
                    compare_value("lsu_exception_o.tval", e.tval, exc.tval);
                end
            end else if (rst_n && valid) begin
                errors++;
                $display("response at %0t ns without an outstanding request", $time);
            end
        end
    end

    initial begin : stimulus
        vpn_t vpn;
        rng          = 32'd49914;
        errors       = 0;
        checks       = 0;
        test_err     = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        en           = 1'b0;
        priv         = PRIV_M;
        sum          = 1'b0;
        flush        = 1'b0;
        upd          = '0;
        req          = '0;
        cfg_en       = 1'b0;
        cfg_priv     = PRIV_M;
        cfg_sum      = 1'b0;
        ref_flush();
        ref_ptr = '0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        // translation off, any address passes through
        for (int i = 0; i < 8; i++) begin
            access(vaddr_t'({xorshift(), xorshift()}), i[0]);
        end
        finish_test("pass-through");

        // 4k page, back-to-back accesses
        cfg_en = 1'b1;
        vpn    = {9'h001, 9'h0a5, 9'h13c};
        fill(vpn, 1'b0, 1'b0, make_pte(ppn_t'({xorshift(), xorshift()}), 1'b0, 1'b1, 1'b1), 1'b0);
        for (int i = 0; i < 8; i++) begin
            access({vpn, 12'(xorshift())}, i[0]);
        end
        finish_test("4k hit");

        // tag bits below the page size are random and must be ignored
        fill({9'h002, 9'h033, 9'(xorshift())}, 1'b1, 1'b0,
             make_pte(ppn_t'({xorshift(), xorshift()}), 1'b0, 1'b1, 1'b1), 1'b0);
        fill({9'h003, 18'(xorshift())}, 1'b0, 1'b1,
             make_pte(ppn_t'({xorshift(), xorshift()}), 1'b0, 1'b1, 1'b1), 1'b0);
        for (int i = 0; i < 8; i++) begin
            access({9'h002, 9'h033, 21'(xorshift())}, 1'b0);
            access({9'h003, 30'(xorshift())}, 1'b1);
        end
        finish_test("superpages");

        // every u, w, d combination, loads and stores in U, S, M with sum 0 and 1
        // vpn[2] has its msb set so tval is sign-extended
        for (int k = 0; k < 8; k++) begin
            vpn = {9'h1f0, 9'(k), 9'(xorshift())};
            fill(vpn, 1'b0, 1'b0, make_pte(ppn_t'({xorshift(), xorshift()}), k[0], k[1], k[2]),
                 1'b0);
            for (int m = 0; m < 6; m++) begin
                cfg_priv = (m < 2) ? PRIV_U : ((m < 4) ? PRIV_S : PRIV_M);
                cfg_sum  = m[0];
                access({vpn, 12'(xorshift())}, 1'b0);
                access({vpn, 12'(xorshift())}, 1'b1);
            end
        end
        cfg_priv = PRIV_M;
        cfg_sum  = 1'b0;
        finish_test("permissions");

        // unmapped page misses, hits after the fill
        vpn = {9'h055, 18'(xorshift())};
        access({vpn, 12'h123}, 1'b0);
        fill(vpn, 1'b0, 1'b0, make_pte(ppn_t'({xorshift(), xorshift()}), 1'b0, 1'b1, 1'b1), 1'b0);
        access({vpn, 12'h123}, 1'b0);
        access({vpn, 12'h456}, 1'b1);
        finish_test("miss and retry");

        // five fills into four entries, the first one is evicted
        step('0, '0, 1'b1);
        for (int k = 0; k < 5; k++) begin
            fill({9'h066, 9'(k), 9'h000}, 1'b0, 1'b0,
                 make_pte(ppn_t'({xorshift(), xorshift()}), 1'b0, 1'b1, 1'b1), 1'b0);
        end
        for (int k = 0; k < 5; k++) begin
            access({9'h066, 9'(k), 9'h000, 12'h000}, 1'b0);
        end
        step('0, '0, 1'b1);
        for (int k = 0; k < 5; k++) begin
            access({9'h066, 9'(k), 9'h000, 12'h000}, 1'b0);
        end
        // fill dropped by a flush in the same cycle
        fill({9'h077, 18'h0}, 1'b0, 1'b0, make_pte(ppn_t'(1), 1'b0, 1'b1, 1'b1), 1'b1);
        access({9'h077, 30'h0}, 1'b0);
        finish_test("replacement and flush");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verif
source/sv39_pkg.sv
source/mmu_pkg.sv
source/dtlb.sv
source/ld_st_translate.sv
source/mmu_data.sv
verif/tb_mmu_data.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mmu_data -o sim_mmu_data

./obj_dir/sim_mmu_data > sim.log
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
